// ==== project.f ====
logic/pcore_pkg.sv
logic/bus_mem_if.sv
logic/eng_mem_if.sv
logic/pcore_bus_adapter.sv
logic/coef_mem.sv
logic/mod_q_lane.sv
logic/poly_arith_engine.sv
logic/pcore_top.sv
testbench/pcore_tb.sv

// ==== testbench/pcore_tb.sv ====
// Directed tests with a fixed-seed model of banks A, B and C; stops at the first mismatch
`timescale 1ns/1ps

module pcore_tb;

    localparam int HOLD_LIMIT = 200;  // Cycles well past one engine run
    localparam int POLL_LIMIT = 100;  // Status reads before giving up

    logic        clk, reset_i, dv_i, write_i;
    logic [11:0] addr_i;
    logic [63:0] wdata_i, rdata_o;
    logic        hold_o, err_o;

    logic [31:0] rng_state;
    int          held_cycles;  // Hold count of the last access
    logic [23:0] ref_a [256];  // Reference banks
    logic [23:0] ref_b [256];
    logic [23:0] ref_c [256];

    pcore_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [23:0] rand_coef();
        return 24'(xorshift_next() % 32'(pcore_pkg::Q));  // Already below q
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                                $time, name, expected, actual));
    endtask

    // One request kept stable while held
    task automatic bus_access(input logic wr, input logic [11:0] addr,
                              input logic [63:0] data, output logic err);
        held_cycles = 0;
        @(posedge clk);
        dv_i    <= 1'b1;
        write_i <= wr;
        addr_i  <= addr;
        wdata_i <= data;
        @(negedge clk);
        while (hold_o) begin
            held_cycles++;
            if (held_cycles > HOLD_LIMIT)
                abort_run("Timeout: hold_o never dropped on a bank access");
            @(negedge clk);
        end
        err = err_o;  // Accept cycle
        @(posedge clk);
        dv_i    <= 1'b0;
        write_i <= 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] addr, input logic [63:0] data,
                             output logic err);
        bus_access(1'b1, addr, data, err);
    endtask

    task automatic bus_read(input logic [11:0] addr, output logic [63:0] data,
                            output logic err);
        bus_access(1'b0, addr, 64'd0, err);
        @(negedge clk);
        data = rdata_o;  // Valid the cycle after acceptance
    endtask

    task automatic write_coef(input int bank, input int idx, input logic [23:0] v);
        logic err;
        bus_write(12'(bank * 256 + idx), {40'd0, v}, err);
        check("err_o on bank write", 1'b0, err);
        case (bank)
            0:       ref_a[idx] = v;
            1:       ref_b[idx] = v;
            default: ref_c[idx] = v;
        endcase
    endtask

    task automatic read_check_coef(input int bank, input int idx);
        logic [63:0] d;
        logic        err;
        logic [23:0] exp_v;
        exp_v = (bank == 0) ? ref_a[idx] : (bank == 1) ? ref_b[idx] : ref_c[idx];
        bus_read(12'(bank * 256 + idx), d, err);
        check($sformatf("rdata_o bank %0d [%0d]", bank, idx), {40'd0, exp_v}, d);
    endtask

    // Programs control, starts the run, then updates the C model
    task automatic start_engine(input pcore_pkg::mode_t mode, input logic acc);
        logic   err;
        longint a, b, r, q;
        q = longint'(pcore_pkg::Q);
        bus_write(pcore_pkg::CTRL_ADDR, {60'd0, acc, mode}, err);
        check("err_o on control write", 1'b0, err);
        bus_write(pcore_pkg::ENABLE_ADDR, 64'd1, err);
        check("err_o on enable write", 1'b0, err);
        for (int i = 0; i < 256; i++) begin
            a = longint'(ref_a[i]);
            b = longint'(ref_b[i]);
            case (mode)
                pcore_pkg::MODE_ADD: r = (a + b) % q;
                pcore_pkg::MODE_SUB: r = (a - b + q) % q;
                default:             r = (a * b) % q;
            endcase
            if (acc)
                r = (r + longint'(ref_c[i])) % q;  // Old C
            ref_c[i] = 24'(r);
        end
    endtask

    task automatic wait_done();
        logic [63:0] status;
        logic        err;
        int          polls;
        polls = 0;
        bus_read(pcore_pkg::ENABLE_ADDR, status, err);
        check("rdata_o status after start", 64'h2, status);  // Busy and old done cleared
        while (!status[2]) begin
            polls++;
            if (polls > POLL_LIMIT)
                abort_run("Timeout: engine never reported done");
            bus_read(pcore_pkg::ENABLE_ADDR, status, err);
        end
    endtask

    task automatic check_bank_c();
        for (int i = 0; i < 256; i++)
            read_check_coef(2, i);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_readback();
        int          banks [12];
        int          idxs [12];
        logic [63:0] d;
        logic        err;
        for (int n = 0; n < 12; n++) begin
            banks[n] = (n < 8) ? n % 3 : 1;               // Last four share one word
            idxs[n]  = (n < 8) ? int'(xorshift_next() % 256) : 36 + n;  // Lanes 0..3
            write_coef(banks[n], idxs[n], rand_coef());
        end
        for (int n = 0; n < 12; n++)
            read_check_coef(banks[n], idxs[n]);
        bus_write(pcore_pkg::CTRL_ADDR, 64'h1234_5678_9abc_def9, err);  // Sub with accumulate
        bus_read(pcore_pkg::CTRL_ADDR, d, err);
        check("rdata_o control raw", 64'h1234_5678_9abc_def9, d);
    endtask

    task automatic test_add();
        for (int i = 0; i < 256; i++) begin
            write_coef(0, i, rand_coef());
            write_coef(1, i, rand_coef());
        end
        write_coef(0, 0, pcore_pkg::Q - 1);  // Sum wraps
        write_coef(1, 0, pcore_pkg::Q - 1);
        write_coef(0, 1, pcore_pkg::Q - 1);  // Sum hits q exactly
        write_coef(1, 1, 24'd1);
        write_coef(0, 2, 24'd3);             // b > a for subtract
        write_coef(1, 2, pcore_pkg::Q - 2);
        write_coef(0, 3, 24'd0);
        write_coef(1, 3, pcore_pkg::Q - 1);
        start_engine(pcore_pkg::MODE_ADD, 1'b0);
        wait_done();
        check_bank_c();
    endtask

    task automatic test_sub();
        start_engine(pcore_pkg::MODE_SUB, 1'b0);
        wait_done();
        check_bank_c();
    endtask

    task automatic test_mul_acc();
        logic [63:0] status;
        logic        err;
        start_engine(pcore_pkg::MODE_MUL, 1'b1);
        wait_done();
        bus_read(pcore_pkg::ENABLE_ADDR, status, err);
        check("rdata_o status done", 64'h4, status);  // Idle with done set
        check_bank_c();
    endtask

    task automatic test_errors_hold();
        logic [63:0] d;
        logic        err;
        logic [23:0] v;
        bus_write(12'd800, 64'd0, err);
        check("err_o unmapped write", 1'b1, err);
        bus_read(12'hfff, d, err);
        check("err_o unmapped read", 1'b1, err);
        bus_write(pcore_pkg::CTRL_ADDR, 64'h5, err);  // Reserved mode
        check("err_o reserved mode", 1'b1, err);
        bus_read(pcore_pkg::CTRL_ADDR, d, err);
        check("rdata_o control kept", 64'ha, d);
        // Bank write right behind start stalls for the run
        start_engine(pcore_pkg::MODE_MUL, 1'b1);
        v = rand_coef();
        write_coef(0, 7, v);
        check("hold_o seen", 1'b1, held_cycles > 0);
        bus_read(pcore_pkg::ENABLE_ADDR, d, err);
        check("rdata_o status after hold", 64'h4, d);
        read_check_coef(0, 7);
        check_bank_c();
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        rng_state = 32'hc571e451;
        reset_i <= 1'b1;
        dv_i    <= 1'b0;
        write_i <= 1'b0;
        addr_i  <= '0;
        wdata_i <= '0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        test_readback();
        test_add();
        test_sub();
        test_mul_acc();
        test_errors_hold();
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== logic/pcore_top.sv ====
// Host bus is the simple dv/hold port; only one engine run at a time
`timescale 1ns/1ps

module pcore_top (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             dv_i,
    input  logic                             write_i,
    input  logic [pcore_pkg::BUS_ADDR_W-1:0] addr_i,
    input  logic [pcore_pkg::BUS_DATA_W-1:0] wdata_i,
    output logic [pcore_pkg::BUS_DATA_W-1:0] rdata_o,
    output logic                             hold_o,
    output logic                             err_o
);

    bus_mem_if bus_mem ();
    eng_mem_if eng_mem ();

    logic             start, busy, done;
    logic             accumulate;
    pcore_pkg::mode_t mode;

    // Host decode, control and status
    pcore_bus_adapter adapter_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .dv_i         (dv_i),
        .write_i      (write_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .rdata_o      (rdata_o),
        .hold_o       (hold_o),
        .err_o        (err_o),
        .mem_o        (bus_mem.requester),
        .start_o      (start),
        .mode_o       (mode),
        .accumulate_o (accumulate),
        .busy_i       (busy),
        .done_i       (done)
    );

    // Banks A, B and C
    coef_mem mem_i (
        .clk   (clk),
        .bus_p (bus_mem.memory),
        .eng_p (eng_mem.memory)
    );

    poly_arith_engine engine_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (start),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .mem_p        (eng_mem.engine),
        .busy_o       (busy),
        .done_o       (done)
    );

endmodule

// ==== logic/poly_arith_engine.sv ====
// Start while busy is ignored; mode and accumulate are sampled once at start
`timescale 1ns/1ps

module poly_arith_engine (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             start_i,
    input  pcore_pkg::mode_t mode_i,
    input  logic             accumulate_i,
    eng_mem_if.engine        mem_p,
    output logic             busy_o,
    output logic             done_o
);

    localparam int W = pcore_pkg::COEF_W * pcore_pkg::LANES;
    localparam logic [pcore_pkg::MEM_ADDR_W-1:0] LAST =
        pcore_pkg::MEM_ADDR_W'(pcore_pkg::MEM_DEPTH - 1);  // Final word

    logic                            busy_q;
    logic                            rd_active_q;  // Issue stage
    logic [pcore_pkg::MEM_ADDR_W-1:0] rd_addr_q;
    logic                            d_valid_q;    // Data stage
    logic [pcore_pkg::MEM_ADDR_W-1:0] d_addr_q;
    logic                            w_valid_q;    // Write stage
    logic [pcore_pkg::MEM_ADDR_W-1:0] w_addr_q;
    pcore_pkg::mode_t                mode_q;
    logic                            acc_q;
    logic [W-1:0]                    result_d, result_q;

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            rd_active_q <= 1'b0;
            rd_addr_q   <= '0;
            d_valid_q   <= 1'b0;
            w_valid_q   <= 1'b0;
            mode_q      <= pcore_pkg::MODE_ADD;
            acc_q       <= 1'b0;
        end else begin
            d_valid_q <= rd_active_q;  // Valid chain follows the read
            w_valid_q <= d_valid_q;
            if (start_i && !busy_q) begin
                busy_q      <= 1'b1;
                rd_active_q <= 1'b1;
                rd_addr_q   <= '0;
                mode_q      <= mode_i;
                acc_q       <= accumulate_i;
            end else if (rd_active_q) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                if (rd_addr_q == LAST)
                    rd_active_q <= 1'b0;  // 64 reads issued
            end
            if (done_o)
                busy_q <= 1'b0;
        end
    end

    // Address and result pipeline
    always_ff @(posedge clk) begin
        d_addr_q <= rd_addr_q;
        w_addr_q <= d_addr_q;
        result_q <= result_d;
    end

    // ==================================================
    // Lane arithmetic
    // ==================================================
    for (genvar l = 0; l < pcore_pkg::LANES; l++) begin : g_lane
        mod_q_lane lane_i (
            .a_i          (mem_p.a_rdata[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W]),
            .b_i          (mem_p.b_rdata[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W]),
            .c_i          (mem_p.c_rdata[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W]),
            .mode_i       (mode_q),
            .accumulate_i (acc_q),
            .result_o     (result_d[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W])
        );
    end

    // Memory port
    assign mem_p.rd_en   = rd_active_q;
    assign mem_p.rd_addr = rd_addr_q;
    assign mem_p.wr_en   = w_valid_q;
    assign mem_p.wr_addr = w_addr_q;
    assign mem_p.wdata   = result_q;

    assign done_o = w_valid_q & (w_addr_q == LAST);  // Last word written
    assign busy_o = busy_q;

endmodule

// ==== logic/mod_q_lane.sv ====
// Inputs must already be below q; reserved modes produce zero
`timescale 1ns/1ps

module mod_q_lane (
    input  logic [pcore_pkg::COEF_W-1:0] a_i,
    input  logic [pcore_pkg::COEF_W-1:0] b_i,
    input  logic [pcore_pkg::COEF_W-1:0] c_i,
    input  pcore_pkg::mode_t             mode_i,
    input  logic                         accumulate_i,
    output logic [pcore_pkg::COEF_W-1:0] result_o
);

    localparam logic [pcore_pkg::COEF_W:0] QX = {1'b0, pcore_pkg::Q};  // One spare bit

    logic [pcore_pkg::COEF_W:0]     sum, diff, wide, acc;
    logic [2*pcore_pkg::COEF_W-1:0] prod, prod_red;

    always_comb begin
        sum      = {1'b0, a_i} + {1'b0, b_i};
        diff     = {1'b0, a_i} - {1'b0, b_i};  // MSB set on borrow
        prod     = a_i * b_i;                  // Below 2^46
        prod_red = prod % pcore_pkg::Q;
        case (mode_i)
            pcore_pkg::MODE_ADD: wide = (sum >= QX) ? sum - QX : sum;
            pcore_pkg::MODE_SUB: wide = diff[pcore_pkg::COEF_W] ? diff + QX : diff;
            pcore_pkg::MODE_MUL: wide = prod_red[pcore_pkg::COEF_W:0];
            default:             wide = '0;
        endcase
        // Accumulate step, one more correction
        acc = {1'b0, wide[pcore_pkg::COEF_W-1:0]} + {1'b0, c_i};
        if (acc >= QX)
            acc = acc - QX;
        result_o = accumulate_i ? acc[pcore_pkg::COEF_W-1:0] : wide[pcore_pkg::COEF_W-1:0];
    end

endmodule

// ==== logic/coef_mem.sv ====
// Contents are undefined after reset; a bus write and engine write never share a bank
`timescale 1ns/1ps

module coef_mem (
    input  logic        clk,
    bus_mem_if.memory   bus_p,
    eng_mem_if.memory   eng_p
);

    localparam int W = pcore_pkg::COEF_W * pcore_pkg::LANES;  // 96-bit word

    logic [W-1:0] bank_a [pcore_pkg::MEM_DEPTH];
    logic [W-1:0] bank_b [pcore_pkg::MEM_DEPTH];
    logic [W-1:0] bank_c [pcore_pkg::MEM_DEPTH];

    // ==================================================
    // Writes, bus per lane and engine whole word
    // ==================================================
    always_ff @(posedge clk) begin
        for (int l = 0; l < pcore_pkg::LANES; l++) begin
            if (bus_p.en && bus_p.we && bus_p.lane_we[l]) begin
                case (bus_p.bank)
                    pcore_pkg::BANK_A:
                        bank_a[bus_p.addr][l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W] <=
                            bus_p.wdata[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W];
                    pcore_pkg::BANK_B:
                        bank_b[bus_p.addr][l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W] <=
                            bus_p.wdata[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W];
                    pcore_pkg::BANK_C:
                        bank_c[bus_p.addr][l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W] <=
                            bus_p.wdata[l*pcore_pkg::COEF_W +: pcore_pkg::COEF_W];
                    default: ;  // No fourth bank
                endcase
            end
        end
        if (eng_p.wr_en)
            bank_c[eng_p.wr_addr] <= eng_p.wdata;  // Engine result
    end

    // ==================================================
    // Registered reads
    // ==================================================
    always_ff @(posedge clk) begin
        if (bus_p.en && !bus_p.we) begin  // Holds between reads
            case (bus_p.bank)
                pcore_pkg::BANK_A: bus_p.rdata <= bank_a[bus_p.addr];
                pcore_pkg::BANK_B: bus_p.rdata <= bank_b[bus_p.addr];
                default:           bus_p.rdata <= bank_c[bus_p.addr];
            endcase
        end
        if (eng_p.rd_en) begin
            eng_p.a_rdata <= bank_a[eng_p.rd_addr];
            eng_p.b_rdata <= bank_b[eng_p.rd_addr];
            eng_p.c_rdata <= bank_c[eng_p.rd_addr];  // Old C for accumulate
        end
    end

endmodule

// ==== logic/pcore_bus_adapter.sv ====
// Host must hold a stalled request stable; bank accesses stall for a whole engine run
`timescale 1ns/1ps

module pcore_bus_adapter (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             dv_i,
    input  logic                             write_i,
    input  logic [pcore_pkg::BUS_ADDR_W-1:0] addr_i,
    input  logic [pcore_pkg::BUS_DATA_W-1:0] wdata_i,
    output logic [pcore_pkg::BUS_DATA_W-1:0] rdata_o,
    output logic                             hold_o,
    output logic                             err_o,
    bus_mem_if.requester                     mem_o,
    output logic                             start_o,
    output pcore_pkg::mode_t                 mode_o,
    output logic                             accumulate_o,
    input  logic                             busy_i,
    input  logic                             done_i
);

    logic                             is_bank, is_ctrl, is_enable;
    logic                             accept;
    logic                             mode_ok;
    logic [pcore_pkg::BUS_ADDR_W-1:0] offset;  // Coefficient index within the bank
    pcore_pkg::ctrl_reg_u             ctrl_q;
    pcore_pkg::ctrl_reg_u             ctrl_wr;  // Incoming write decoded
    logic                             done_q;   // Sticky done
    logic                             rd_mem_q;  // Next rdata comes from memory
    logic [1:0]                       lane_q;
    logic [pcore_pkg::BUS_DATA_W-1:0] reg_rdata_q;

    // ==================================================
    // Address decode
    // ==================================================
    always_comb begin
        is_bank   = addr_i < pcore_pkg::CTRL_ADDR;
        is_ctrl   = addr_i == pcore_pkg::CTRL_ADDR;
        is_enable = addr_i == pcore_pkg::ENABLE_ADDR;
        if (addr_i >= pcore_pkg::C_BASE) begin
            mem_o.bank = pcore_pkg::BANK_C;
            offset     = addr_i - pcore_pkg::C_BASE;
        end else if (addr_i >= pcore_pkg::B_BASE) begin
            mem_o.bank = pcore_pkg::BANK_B;
            offset     = addr_i - pcore_pkg::B_BASE;
        end else begin
            mem_o.bank = pcore_pkg::BANK_A;
            offset     = addr_i - pcore_pkg::A_BASE;
        end
    end

    // Handshake and checks
    always_comb begin
        ctrl_wr.raw = wdata_i;
        mode_ok = ctrl_wr.f.mode inside {pcore_pkg::MODE_ADD, pcore_pkg::MODE_SUB,
                                         pcore_pkg::MODE_MUL};
        hold_o  = dv_i & is_bank & busy_i;  // Engine owns the banks
        accept  = dv_i & ~hold_o;
        err_o   = accept & (~(is_bank | is_ctrl | is_enable)
                            | (write_i & is_ctrl & ~mode_ok));
        start_o = accept & write_i & is_enable & wdata_i[0] & ~busy_i;  // Ignored while busy
    end

    // Memory request with word = offset / 4 and lane = offset mod 4
    assign mem_o.en      = accept & is_bank;
    assign mem_o.we      = write_i;
    assign mem_o.addr    = offset[7:2];
    assign mem_o.lane_we = {pcore_pkg::LANES{write_i}} & (4'b0001 << offset[1:0]);
    assign mem_o.wdata   = {pcore_pkg::LANES{wdata_i[pcore_pkg::COEF_W-1:0]}};

    // Engine sees the struct view
    assign mode_o       = ctrl_q.f.mode;
    assign accumulate_o = ctrl_q.f.accumulate;

    // ==================================================
    // Registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q.raw <= '0;  // Add without accumulate
            done_q     <= 1'b0;
            rd_mem_q   <= 1'b0;
        end else begin
            if (accept && write_i && is_ctrl && mode_ok)
                ctrl_q.raw <= wdata_i;  // Reserved modes never land
            if (start_o)
                done_q <= 1'b0;
            else if (done_i)
                done_q <= 1'b1;
            if (accept && !write_i)
                rd_mem_q <= is_bank;
        end
    end

    // Read source and lane capture
    always_ff @(posedge clk) begin
        if (accept && !write_i) begin
            lane_q <= offset[1:0];
            if (is_ctrl)
                reg_rdata_q <= ctrl_q.raw;
            else if (is_enable)
                reg_rdata_q <= {61'd0, done_q, busy_i, 1'b0};  // Status bits
            else
                reg_rdata_q <= '0;  // Unmapped or bank
        end
    end

    assign rdata_o = rd_mem_q ?
        {{(pcore_pkg::BUS_DATA_W - pcore_pkg::COEF_W){1'b0}},
         mem_o.rdata[lane_q*pcore_pkg::COEF_W +: pcore_pkg::COEF_W]} :
        reg_rdata_q;

endmodule

// ==== logic/eng_mem_if.sv ====
// Engine side of the coefficient memory; reads hit all banks, writes go to bank C only
`timescale 1ns/1ps

interface eng_mem_if;
    // Read port, same word in A, B and C
    logic                                         rd_en;
    logic [pcore_pkg::MEM_ADDR_W-1:0]             rd_addr;
    logic [pcore_pkg::COEF_W*pcore_pkg::LANES-1:0] a_rdata;
    logic [pcore_pkg::COEF_W*pcore_pkg::LANES-1:0] b_rdata;
    logic [pcore_pkg::COEF_W*pcore_pkg::LANES-1:0] c_rdata;

    // Write port, all four lanes of bank C
    logic                                         wr_en;
    logic [pcore_pkg::MEM_ADDR_W-1:0]             wr_addr;
    logic [pcore_pkg::COEF_W*pcore_pkg::LANES-1:0] wdata;

    modport engine (
        output rd_en, rd_addr, wr_en, wr_addr, wdata,
        input  a_rdata, b_rdata, c_rdata
    );

    modport memory (
        input  rd_en, rd_addr, wr_en, wr_addr, wdata,
        output a_rdata, b_rdata, c_rdata
    );
endinterface

// ==== logic/bus_mem_if.sv ====
// Bus side of the coefficient memory; rdata arrives one cycle after a read enable
`timescale 1ns/1ps

interface bus_mem_if;
    logic                                         en;
    logic                                         we;
    pcore_pkg::bank_t                             bank;
    logic [pcore_pkg::MEM_ADDR_W-1:0]             addr;
    logic [pcore_pkg::LANES-1:0]                  lane_we;  // One-hot on writes
    logic [pcore_pkg::COEF_W*pcore_pkg::LANES-1:0] wdata;    // Coefficient on every lane
    logic [pcore_pkg::COEF_W*pcore_pkg::LANES-1:0] rdata;    // Whole word

    modport requester (
        output en, we, bank, addr, lane_we, wdata,
        input  rdata
    );

    modport memory (
        input  en, we, bank, addr, lane_we, wdata,
        output rdata
    );
endinterface

// ==== logic/pcore_pkg.sv ====
// Fixed q = 8380417 with 24-bit lanes; host addresses count coefficients, not bytes
package pcore_pkg;

    // ==================================================
    // Sizes and modulus
    // ==================================================
    localparam int COEF_W     = 24;  // One coefficient lane
    localparam int LANES      = 4;   // Coefficients per memory word
    localparam int MEM_DEPTH  = 64;  // Words per bank
    localparam int MEM_ADDR_W = 6;
    localparam int BUS_ADDR_W = 12;
    localparam int BUS_DATA_W = 64;

    localparam logic [COEF_W-1:0] Q = 24'd8380417;

    // Address map, in coefficients
    localparam logic [BUS_ADDR_W-1:0] A_BASE      = 12'd0;
    localparam logic [BUS_ADDR_W-1:0] B_BASE      = 12'd256;
    localparam logic [BUS_ADDR_W-1:0] C_BASE      = 12'd512;
    localparam logic [BUS_ADDR_W-1:0] CTRL_ADDR   = 12'd768;
    localparam logic [BUS_ADDR_W-1:0] ENABLE_ADDR = 12'd769;  // Bit 0 start, 1 busy, 2 done

    // Bank select
    typedef logic [1:0] bank_t;
    localparam bank_t BANK_A = 2'd0;
    localparam bank_t BANK_B = 2'd1;
    localparam bank_t BANK_C = 2'd2;

    // Operation codes, 3..7 reserved
    typedef logic [2:0] mode_t;
    localparam mode_t MODE_ADD = 3'd0;
    localparam mode_t MODE_SUB = 3'd1;
    localparam mode_t MODE_MUL = 3'd2;

    // ==================================================
    // Control register views
    // ==================================================
    typedef struct packed {
        logic [59:0] pad;         // Reads back as written
        logic        accumulate;  // Bit 3
        mode_t       mode;        // Bits 2:0
    } ctrl_fields_t;

    typedef union packed {
        logic [BUS_DATA_W-1:0] raw;  // Host view
        ctrl_fields_t          f;    // Decoded view
    } ctrl_reg_u;

endpackage
